//--- filelist.f
rv_dec_pkg.sv
rv_base_decoder.sv
rv_muldiv_decoder.sv
rv_decoder_mux.sv
rv_decoder_stage.sv
tb_decoder_sva.sv
tb_rv_decoder.sv

//--- rv_base_decoder.sv
`timescale 1ns/1ps

module rv_base_decoder
  import rv_dec_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_rdata,
  output logic               illegal_insn,
  output logic               alu_en,
  output logic               div_en,
  output logic               mul_en,
  output logic               csr_en,
  output logic               sys_en,
  output logic               lsu_en,
  output logic               lsu_we,
  output logic               rd_we,
  output op_a_sel_e          op_a_sel,
  output op_b_sel_e          op_b_sel,
  output op_c_sel_e          op_c_sel,
  output alu_op_e            alu_op,
  output md_op_e             md_op
);

  // Operand-free system words are matched on all 32 bits
  localparam logic [INSTR_W-1:0] INSN_ECALL  = 32'h0000_0073;
  localparam logic [INSTR_W-1:0] INSN_EBREAK = 32'h0010_0073;
  localparam logic [INSTR_W-1:0] INSN_MRET   = 32'h3020_0073;
  localparam logic [INSTR_W-1:0] INSN_WFI    = 32'h1050_0073;

  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  logic                opimm_ok;
  logic                is_op, is_opimm, is_lui, is_auipc, is_jal, is_jalr;
  logic                is_branch, is_load, is_store, is_csr, is_sys;

  assign opcode = instr_rdata[6:0];
  assign funct3 = instr_rdata[14:12];
  assign funct7 = instr_rdata[31:25];

  // Shared funct3 map of OP and OPIMM, alt selects sub or sra
  function automatic alu_op_e arith_op(logic [FUNCT3_W-1:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // On shifts the upper immediate bits act as funct7 and must be plain, or alternate for srai
  assign opimm_ok = (funct3 == 3'b001) ? (funct7 == '0) :
                    (funct3 == 3'b101) ? ((funct7 == '0) || (funct7 == FUNCT7_ALT)) : 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Instruction classes
  //////////////////////////////////////////////////////////////////////

  // Opcode compares include bits 1:0, so compressed words fall through as illegal
  assign is_op     = (opcode == OPCODE_OP) && ((funct7 == '0) ||
                     ((funct7 == FUNCT7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
  assign is_opimm  = (opcode == OPCODE_OPIMM) && opimm_ok;
  assign is_lui    = (opcode == OPCODE_LUI);
  assign is_auipc  = (opcode == OPCODE_AUIPC);
  assign is_jal    = (opcode == OPCODE_JAL);
  assign is_jalr   = (opcode == OPCODE_JALR) && (funct3 == 3'b000);
  // funct3 2 and 3 are unused branch encodings
  assign is_branch = (opcode == OPCODE_BRANCH) && (funct3[2:1] != 2'b01);
  assign is_load   = (opcode == OPCODE_LOAD) && (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
  assign is_store  = (opcode == OPCODE_STORE) && (funct3 inside {3'd0, 3'd1, 3'd2});
  // funct3 4 on SYSTEM is reserved, funct3 0 holds the operand-free words
  assign is_csr    = (opcode == OPCODE_SYSTEM) && (funct3 != 3'd0) && (funct3 != 3'd4);
  assign is_sys    = (instr_rdata inside {INSN_ECALL, INSN_EBREAK, INSN_MRET, INSN_WFI}) ||
                     ((opcode == OPCODE_FENCE) && (funct3[2:1] == 2'b00));

  //////////////////////////////////////////////////////////////////////
  // Control bundle
  //////////////////////////////////////////////////////////////////////

  // Each output is built from the class flags, so an unmatched word leaves all of them idle
  assign alu_en       = is_op || is_opimm || is_lui || is_auipc || is_jal || is_jalr ||
                        is_branch;
  assign lsu_en       = is_load || is_store;
  assign lsu_we       = is_store;
  assign csr_en       = is_csr;
  assign sys_en       = is_sys;
  assign rd_we        = is_op || is_opimm || is_lui || is_auipc || is_jal || is_jalr ||
                        is_load || is_csr;
  assign illegal_insn = !(alu_en || lsu_en || csr_en || sys_en);

  // The M extension is handled next door
  assign mul_en = 1'b0;
  assign div_en = 1'b0;
  assign md_op  = MD_MUL;

  // lui adds its immediate to zero, auipc and jal add it to the pc
  assign op_a_sel = is_lui                                    ? OP_A_ZERO :
                    (is_auipc || is_jal)                      ? OP_A_PC   :
                    (is_op || is_opimm || is_jalr || is_branch ||
                     is_load || is_store || is_csr)           ? OP_A_RS1  : OP_A_NONE;
  assign op_b_sel = (is_op || is_branch)                      ? OP_B_RS2  :
                    (is_opimm || is_lui || is_auipc || is_jal ||
                     is_jalr || is_load || is_store)          ? OP_B_IMM  : OP_B_NONE;
  assign op_c_sel = (is_jal || is_jalr) ? OP_C_LINK :
                    is_store            ? OP_C_RS2  : OP_C_NONE;

  // Jump targets and load/store addresses are plain sums, so only arithmetic and branches differ
  always_comb begin
    alu_op = ALU_ADD;
    if (is_op) begin
      alu_op = arith_op(funct3, funct7[5]);
    end else if (is_opimm) begin
      alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
    end else if (is_branch) begin
      case (funct3)
        3'b000:  alu_op = ALU_EQ;
        3'b001:  alu_op = ALU_NE;
        3'b100:  alu_op = ALU_LT;
        3'b101:  alu_op = ALU_GE;
        3'b110:  alu_op = ALU_LTU;
        default: alu_op = ALU_GEU;
      endcase
    end
  end

endmodule

//--- rv_dec_pkg.sv
package rv_dec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Only uncompressed words reach the decoder
  localparam int INSTR_W  = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes and funct7 markers
  //////////////////////////////////////////////////////////////////////

  // Every major opcode ends in 2'b11, so a compressed word never equals one of these
  localparam logic [OPCODE_W-1:0] OPCODE_LOAD   = 7'h03;
  localparam logic [OPCODE_W-1:0] OPCODE_FENCE  = 7'h0f;
  localparam logic [OPCODE_W-1:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [OPCODE_W-1:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [OPCODE_W-1:0] OPCODE_STORE  = 7'h23;
  localparam logic [OPCODE_W-1:0] OPCODE_AMO    = 7'h2f;
  localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'h33;
  localparam logic [OPCODE_W-1:0] OPCODE_LUI    = 7'h37;
  localparam logic [OPCODE_W-1:0] OPCODE_BRANCH = 7'h63;
  localparam logic [OPCODE_W-1:0] OPCODE_JALR   = 7'h67;
  localparam logic [OPCODE_W-1:0] OPCODE_JAL    = 7'h6f;
  localparam logic [OPCODE_W-1:0] OPCODE_SYSTEM = 7'h73;

  // M extension words on OPCODE_OP, and the alternate form for sub, sra and srai
  localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b000_0001;
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT    = 7'b010_0000;

  //////////////////////////////////////////////////////////////////////
  // Operand selects and operators
  //////////////////////////////////////////////////////////////////////

  // First operand of the ALU or divider, CSR write data, LSU base address
  typedef enum logic [1:0] {
    OP_A_NONE = 2'b00,
    OP_A_RS1  = 2'b01,
    OP_A_PC   = 2'b10,
    OP_A_ZERO = 2'b11
  } op_a_sel_e;

  // Second operand, either the register or the immediate
  typedef enum logic [1:0] {
    OP_B_NONE = 2'b00,
    OP_B_RS2  = 2'b01,
    OP_B_IMM  = 2'b10
  } op_b_sel_e;

  // Third operand carries store data or the link address of a jump
  typedef enum logic [1:0] {
    OP_C_NONE = 2'b00,
    OP_C_RS2  = 2'b01,
    OP_C_LINK = 2'b10
  } op_c_sel_e;

  // ALU_ADD is zero and doubles as the idle operator
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_SLL  = 4'h2,
    ALU_SLT  = 4'h3,
    ALU_SLTU = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_OR   = 4'h8,
    ALU_AND  = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Encoded exactly as funct3 of the M instruction
  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
    MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } md_op_e;

endpackage

//--- rv_decoder_mux.sv
`timescale 1ns/1ps

module rv_decoder_mux
  import rv_dec_pkg::*;
#(
  parameter bit M_EXT = 1'b1
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid,
  // RV32I bundle
  input  logic      base_illegal_insn, base_alu_en, base_div_en, base_mul_en, base_csr_en,
  input  logic      base_sys_en, base_lsu_en, base_lsu_we, base_rd_we,
  input  op_a_sel_e base_op_a_sel,
  input  op_b_sel_e base_op_b_sel,
  input  op_c_sel_e base_op_c_sel,
  input  alu_op_e   base_alu_op,
  input  md_op_e    base_md_op,
  // M extension bundle
  input  logic      md_illegal_insn, md_alu_en, md_div_en, md_mul_en, md_csr_en,
  input  logic      md_sys_en, md_lsu_en, md_lsu_we, md_rd_we,
  input  op_a_sel_e md_op_a_sel,
  input  op_b_sel_e md_op_b_sel,
  input  op_c_sel_e md_op_c_sel,
  input  alu_op_e   md_alu_op,
  input  md_op_e    md_md_op,
  // Registered result
  output logic      out_valid,
  output logic      illegal_insn, alu_en, div_en, mul_en, csr_en,
  output logic      sys_en, lsu_en, lsu_we, rd_we,
  output op_a_sel_e op_a_sel,
  output op_b_sel_e op_b_sel,
  output op_c_sel_e op_c_sel,
  output alu_op_e   alu_op,
  output md_op_e    md_op
);

  logic use_base;
  logic use_md;

  // Base has priority, the M bundle counts only when the extension is built in
  assign use_base = !base_illegal_insn;
  assign use_md   = M_EXT && base_illegal_insn && !md_illegal_insn;

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid    <= 1'b0;
      illegal_insn <= 1'b0;
      alu_en       <= 1'b0;
      div_en       <= 1'b0;
      mul_en       <= 1'b0;
      csr_en       <= 1'b0;
      sys_en       <= 1'b0;
      lsu_en       <= 1'b0;
      lsu_we       <= 1'b0;
      rd_we        <= 1'b0;
      op_a_sel     <= OP_A_NONE;
      op_b_sel     <= OP_B_NONE;
      op_c_sel     <= OP_C_NONE;
      alu_op       <= ALU_ADD;
      md_op        <= MD_MUL;
    end else begin
      out_valid <= instr_valid;
      // Unselected bundles are idle, so OR-ing the gated flags picks the winner
      // and leaves only illegal_insn set when nothing matched
      if (instr_valid) begin
        illegal_insn <= !(use_base || use_md);
        alu_en       <= (use_base && base_alu_en) || (use_md && md_alu_en);
        div_en       <= (use_base && base_div_en) || (use_md && md_div_en);
        mul_en       <= (use_base && base_mul_en) || (use_md && md_mul_en);
        csr_en       <= (use_base && base_csr_en) || (use_md && md_csr_en);
        sys_en       <= (use_base && base_sys_en) || (use_md && md_sys_en);
        lsu_en       <= (use_base && base_lsu_en) || (use_md && md_lsu_en);
        lsu_we       <= (use_base && base_lsu_we) || (use_md && md_lsu_we);
        rd_we        <= (use_base && base_rd_we) || (use_md && md_rd_we);
        // A matched M word with the extension off must not leak its selects
        op_a_sel     <= use_base ? base_op_a_sel : (use_md ? md_op_a_sel : OP_A_NONE);
        op_b_sel     <= use_base ? base_op_b_sel : (use_md ? md_op_b_sel : OP_B_NONE);
        op_c_sel     <= use_base ? base_op_c_sel : (use_md ? md_op_c_sel : OP_C_NONE);
        alu_op       <= use_base ? base_alu_op : (use_md ? md_alu_op : ALU_ADD);
        md_op        <= use_base ? base_md_op : (use_md ? md_md_op : MD_MUL);
      end
    end
  end

endmodule

//--- rv_decoder_stage.sv
`timescale 1ns/1ps

module rv_decoder_stage
  import rv_dec_pkg::*;
#(
  parameter bit M_EXT = 1'b1
)
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  logic [INSTR_W-1:0] instr_rdata,
  output logic               out_valid,
  output logic               illegal_insn, alu_en, div_en, mul_en, csr_en,
  output logic               sys_en, lsu_en, lsu_we, rd_we,
  output op_a_sel_e          op_a_sel,
  output op_b_sel_e          op_b_sel,
  output op_c_sel_e          op_c_sel,
  output alu_op_e            alu_op,
  output md_op_e             md_op
);

  // Bundles from the two sub-decoders, named as the mux ports expect them
  logic      base_illegal_insn, base_alu_en, base_div_en, base_mul_en, base_csr_en;
  logic      base_sys_en, base_lsu_en, base_lsu_we, base_rd_we;
  op_a_sel_e base_op_a_sel;
  op_b_sel_e base_op_b_sel;
  op_c_sel_e base_op_c_sel;
  alu_op_e   base_alu_op;
  md_op_e    base_md_op;
  logic      md_illegal_insn, md_alu_en, md_div_en, md_mul_en, md_csr_en;
  logic      md_sys_en, md_lsu_en, md_lsu_we, md_rd_we;
  op_a_sel_e md_op_a_sel;
  op_b_sel_e md_op_b_sel;
  op_c_sel_e md_op_c_sel;
  alu_op_e   md_alu_op;
  md_op_e    md_md_op;

  // Both decoders see every word in the same cycle
  rv_base_decoder base_decoder_inst (
    .instr_rdata(instr_rdata), .illegal_insn(base_illegal_insn), .alu_en(base_alu_en),
    .div_en(base_div_en), .mul_en(base_mul_en), .csr_en(base_csr_en),
    .sys_en(base_sys_en), .lsu_en(base_lsu_en), .lsu_we(base_lsu_we), .rd_we(base_rd_we),
    .op_a_sel(base_op_a_sel), .op_b_sel(base_op_b_sel), .op_c_sel(base_op_c_sel),
    .alu_op(base_alu_op), .md_op(base_md_op)
  );

  rv_muldiv_decoder md_decoder_inst (
    .instr_rdata(instr_rdata), .illegal_insn(md_illegal_insn), .alu_en(md_alu_en),
    .div_en(md_div_en), .mul_en(md_mul_en), .csr_en(md_csr_en),
    .sys_en(md_sys_en), .lsu_en(md_lsu_en), .lsu_we(md_lsu_we), .rd_we(md_rd_we),
    .op_a_sel(md_op_a_sel), .op_b_sel(md_op_b_sel), .op_c_sel(md_op_c_sel),
    .alu_op(md_alu_op), .md_op(md_md_op)
  );

  // Every mux port has a same-named signal at this level
  rv_decoder_mux #(.M_EXT(M_EXT)) mux_inst (.*);

endmodule

//--- rv_muldiv_decoder.sv
`timescale 1ns/1ps

module rv_muldiv_decoder
  import rv_dec_pkg::*;
(
  input  logic [INSTR_W-1:0] instr_rdata,
  output logic               illegal_insn,
  output logic               alu_en,
  output logic               div_en,
  output logic               mul_en,
  output logic               csr_en,
  output logic               sys_en,
  output logic               lsu_en,
  output logic               lsu_we,
  output logic               rd_we,
  output op_a_sel_e          op_a_sel,
  output op_b_sel_e          op_b_sel,
  output op_c_sel_e          op_c_sel,
  output alu_op_e            alu_op,
  output md_op_e             md_op
);

  logic [FUNCT3_W-1:0] funct3;
  logic                match;

  assign funct3 = instr_rdata[14:12];

  // Only OP words with the muldiv funct7 belong here
  assign match = (instr_rdata[6:0] == OPCODE_OP) && (instr_rdata[31:25] == FUNCT7_MULDIV);

  // funct3[2] splits multiplies from divides and remainders
  assign mul_en       = match && !funct3[2];
  assign div_en       = match && funct3[2];
  assign rd_we        = match;
  assign illegal_insn = !match;

  // Multiplier reads its operands directly, the divider takes them through the A/B path
  assign op_a_sel = div_en ? OP_A_RS1 : OP_A_NONE;
  assign op_b_sel = div_en ? OP_B_RS2 : OP_B_NONE;
  assign op_c_sel = OP_C_NONE;
  assign md_op    = match ? md_op_e'(funct3) : MD_MUL;

  // No other unit is ever touched by an M instruction
  assign alu_en = 1'b0;
  assign csr_en = 1'b0;
  assign sys_en = 1'b0;
  assign lsu_en = 1'b0;
  assign lsu_we = 1'b0;
  assign alu_op = ALU_ADD;

endmodule

//--- tb_decoder_sva.sv
`timescale 1ns/1ps

module tb_decoder_sva
  import rv_dec_pkg::*;
(
  input logic               clk,
  input logic               rst_n,
  input logic               instr_valid,
  // Word whose decode is currently on the outputs
  input logic [INSTR_W-1:0] instr_q,
  input logic               out_valid,
  input logic               illegal_insn, alu_en, div_en, mul_en, csr_en,
  input logic               sys_en, lsu_en, lsu_we, rd_we,
  input op_a_sel_e          op_a_sel,
  input op_b_sel_e          op_b_sel,
  input op_c_sel_e          op_c_sel,
  input alu_op_e            alu_op,
  input md_op_e             md_op
);

  int                  fail_count = 0;
  logic                rst_d = 1'b0;
  logic                rst_d2 = 1'b0;
  logic                valid_d = 1'b0;
  logic [OPCODE_W-1:0] opcode;
  logic                known_op;
  logic                bad_word;
  logic                idle;

  assign opcode   = instr_q[6:0];
  // AMO is in the package but never legal here
  assign known_op = opcode inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
                                   OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD,
                                   OPCODE_STORE, OPCODE_SYSTEM, OPCODE_FENCE};
  assign bad_word = (opcode == OPCODE_AMO) || (instr_q[1:0] != 2'b11) || !known_op;
  // ALU_ADD and MD_MUL are the zero encodings of the two operators
  assign idle     = !alu_en && !div_en && !mul_en && !csr_en && !sys_en && !lsu_en &&
                    !lsu_we && !rd_we && (op_a_sel == OP_A_NONE) &&
                    (op_b_sel == OP_B_NONE) && (op_c_sel == OP_C_NONE) &&
                    (alu_op == ALU_ADD) && (md_op == MD_MUL);

  // The result of an edge appears one cycle later, so track valid and reset by one edge
  always @(posedge clk) begin
    rst_d   <= rst_n;
    rst_d2  <= rst_d;
    valid_d <= rst_n && instr_valid;
  end

  // Outputs are settled half a cycle after the edge that wrote them
  always @(negedge clk) begin
    assert (out_valid == valid_d) else begin
      $display("MISMATCH at %0t: out_valid expected %b actual %b", $time, valid_d, out_valid);
      fail_count++;
    end
    // Covers every cycle in reset and the first cycle out of it
    if (!rst_d || !rst_d2) begin
      assert (!out_valid && !illegal_insn && idle) else begin
        $display("Outputs not idle during or right after reset at %0t", $time);
        fail_count++;
      end
    end
    if (out_valid) begin
      assert ($countones({illegal_insn, alu_en, div_en, mul_en, csr_en, sys_en, lsu_en}) == 1)
      else begin
        $display("Unit enables not one-hot at %0t for word %h", $time, instr_q);
        fail_count++;
      end
      assert (!illegal_insn || idle) else begin
        $display("Illegal result still drives controls at %0t for word %h", $time, instr_q);
        fail_count++;
      end
      // A and B operands only feed units that read them through the operand path
      assert (((op_a_sel == OP_A_NONE) && (op_b_sel == OP_B_NONE)) ||
              ((alu_en || div_en || csr_en || lsu_en) && !mul_en && !sys_en)) else begin
        $display("A/B operand select with a unit that takes none at %0t", $time);
        fail_count++;
      end
      assert ((op_c_sel == OP_C_NONE) || alu_en || (lsu_en && lsu_we)) else begin
        $display("C operand select outside ALU or store at %0t", $time);
        fail_count++;
      end
      assert (!bad_word || illegal_insn) else begin
        $display("MISMATCH at %0t: illegal_insn expected 1 actual %b for word %h",
                 $time, illegal_insn, instr_q);
        fail_count++;
      end
    end
  end

endmodule

//--- tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder
  import rv_dec_pkg::*;
;

  localparam int CLK_PERIOD   = 20;
  localparam int RANDOM_COUNT = 2000;
  localparam int SEED         = 92928;

  // Unit classes of the reference model
  localparam int UNIT_ILLEGAL = 0;
  localparam int UNIT_ALU     = 1;
  localparam int UNIT_MUL     = 2;
  localparam int UNIT_DIV     = 3;
  localparam int UNIT_CSR     = 4;
  localparam int UNIT_SYS     = 5;
  localparam int UNIT_LOAD    = 6;
  localparam int UNIT_STORE   = 7;

  localparam logic [OPCODE_W-1:0] LEGAL_OPS [11] = '{OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI,
    OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE,
    OPCODE_SYSTEM, OPCODE_FENCE};

  logic               clk = 1'b0;
  logic               rst_n;
  logic               instr_valid;
  logic [INSTR_W-1:0] instr_rdata;
  logic [INSTR_W-1:0] instr_q;
  logic               out_valid;
  logic               illegal_insn, alu_en, div_en, mul_en, csr_en;
  logic               sys_en, lsu_en, lsu_we, rd_we;
  op_a_sel_e          op_a_sel;
  op_b_sel_e          op_b_sel;
  op_c_sel_e          op_c_sel;
  alu_op_e            alu_op;
  md_op_e             md_op;
  logic [INSTR_W-1:0] word_q[$];
  logic               list_ready = 1'b0;
  int                 model_errors = 0;
  int                 sent_count = 0;
  int                 checked_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_decoder_stage #(.M_EXT(1'b1)) rv_decoder_stage_inst (.*);

  tb_decoder_sva sva_inst (.*);

  // Keep the word that belongs to the result the DUT shows next
  always @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr_rdata;
    end
  end

  // Builds an R-type shaped word with rd 3, rs1 1 and rs2 2
  function automatic logic [INSTR_W-1:0] make_word(logic [6:0] f7, logic [2:0] f3,
                                                   logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, 5'd3, op};
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reference model, unit class straight from the RV32IM encoding
  ////////////////////////////////////////////////////////////////////

  function automatic int expected_unit(logic [INSTR_W-1:0] w);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    int         unit;
    op   = w[6:0];
    f3   = w[14:12];
    f7   = w[31:25];
    unit = UNIT_ILLEGAL;
    case (op)
      OPCODE_OP: begin
        if (f7 == FUNCT7_MULDIV) begin
          unit = f3[2] ? UNIT_DIV : UNIT_MUL;
        end else if ((f7 == 7'd0) || ((f7 == FUNCT7_ALT) && (f3 == 3'd0 || f3 == 3'd5))) begin
          unit = UNIT_ALU;
        end
      end
      // Shift immediates reuse the funct7 field
      OPCODE_OPIMM: begin
        if ((f3 != 3'd1 && f3 != 3'd5) || (f7 == 7'd0) || (f3 == 3'd5 && f7 == FUNCT7_ALT)) begin
          unit = UNIT_ALU;
        end
      end
      OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: unit = UNIT_ALU;
      OPCODE_JALR:   unit = (f3 == 3'd0) ? UNIT_ALU : UNIT_ILLEGAL;
      OPCODE_BRANCH: unit = (f3 == 3'd2 || f3 == 3'd3) ? UNIT_ILLEGAL : UNIT_ALU;
      OPCODE_LOAD:   unit = (f3 == 3'd3 || f3 > 3'd5) ? UNIT_ILLEGAL : UNIT_LOAD;
      OPCODE_STORE:  unit = (f3 <= 3'd2) ? UNIT_STORE : UNIT_ILLEGAL;
      OPCODE_FENCE:  unit = (f3 <= 3'd1) ? UNIT_SYS : UNIT_ILLEGAL;
      OPCODE_SYSTEM: begin
        if (f3 == 3'd0) begin
          // ecall, ebreak, mret, wfi
          if (w inside {32'h0000_0073, 32'h0010_0073, 32'h3020_0073, 32'h1050_0073}) begin
            unit = UNIT_SYS;
          end
        end else if (f3 != 3'd4) begin
          unit = UNIT_CSR;
        end
      end
      default: unit = UNIT_ILLEGAL;
    endcase
    return unit;
  endfunction

  always @(negedge clk) begin : scoreboard
    int exp_unit;
    int act_unit;
    if (out_valid) begin
      exp_unit = expected_unit(instr_q);
      act_unit = illegal_insn ? UNIT_ILLEGAL : alu_en ? UNIT_ALU : mul_en ? UNIT_MUL :
                 div_en ? UNIT_DIV : csr_en ? UNIT_CSR : sys_en ? UNIT_SYS :
                 lsu_en ? (lsu_we ? UNIT_STORE : UNIT_LOAD) : -1;
      checked_count++;
      assert (act_unit == exp_unit) else begin
        $display("MISMATCH at %0t: unit expected %0d actual %0d for word %h",
                 $time, exp_unit, act_unit, instr_q);
        model_errors++;
      end
      assert (lsu_we == (exp_unit == UNIT_STORE)) else begin
        $display("MISMATCH at %0t: lsu_we expected %b actual %b for word %h",
                 $time, exp_unit == UNIT_STORE, lsu_we, instr_q);
        model_errors++;
      end
    end
  end

  task automatic send_word(input logic [INSTR_W-1:0] word);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr_rdata <= word;
    sent_count++;
  endtask

  initial begin : watchdog
    wait (list_ready);
    #((word_q.size() + RANDOM_COUNT + 50) * CLK_PERIOD);
    $display("Watchdog expired before the test finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    logic [INSTR_W-1:0] word;
    int                 total;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr_rdata = '0;
    // One word per class, then illegal shapes
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_OP));
    word_q.push_back(make_word(FUNCT7_ALT, 3'd0, OPCODE_OP));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_OPIMM));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_LUI));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_AUIPC));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_JAL));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_JALR));
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_BRANCH));
    word_q.push_back(make_word(7'd0, 3'd2, OPCODE_LOAD));
    word_q.push_back(make_word(7'd0, 3'd2, OPCODE_STORE));
    word_q.push_back(make_word(7'd0, 3'd1, OPCODE_SYSTEM));
    word_q.push_back(32'h0000_0073);
    word_q.push_back(32'h0010_0073);
    word_q.push_back(32'h3020_0073);
    word_q.push_back(32'h1050_0073);
    word_q.push_back(make_word(7'd0, 3'd0, OPCODE_FENCE));
    for (int f3 = 0; f3 < 8; f3++) begin
      word_q.push_back(make_word(FUNCT7_MULDIV, f3[2:0], OPCODE_OP));
    end
    word_q.push_back(make_word(7'd0, 3'd2, OPCODE_AMO));
    word_q.push_back(32'h0000_4501);
    word_q.push_back(make_word(7'd0, 3'd0, 7'h0b));
    word_q.push_back(make_word(7'd0, 3'd0, 7'h7f));
    list_ready = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (word_q[i]) begin
      send_word(word_q[i]);
    end
    // Even words land on a legal opcode, often with a funct7 the decoder cares about
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      word = $urandom;
      if (i % 2 == 0) begin
        word[6:0] = LEGAL_OPS[$urandom % 11];
        case ($urandom % 4)
          0:       word[31:25] = 7'd0;
          1:       word[31:25] = FUNCT7_ALT;
          2:       word[31:25] = FUNCT7_MULDIV;
          default: word[31:25] = word[31:25];
        endcase
      end
      send_word(word);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (checked_count != sent_count) begin
      $display("Only %0d of %0d words produced a result", checked_count, sent_count);
    end
    total = sva_inst.fail_count + model_errors + (sent_count - checked_count);
    $display("Errors: %0d assertion, %0d model, %0d missing results",
             sva_inst.fail_count, model_errors, sent_count - checked_count);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
